// ==== src/axi_store_pkg.sv ====
package axi_store_pkg;

    // ceiling log2, zero for a count of one or less
    function automatic int clog2_f(input int n);
        int r;
        int v;
        r = 0;
        v = 1;
        while (v < n) begin
            v = v * 2;
            r = r + 1;
        end
        return r;
    endfunction

    // default widths, copied by the top level
    localparam int USER_DW_C    = 16;
    localparam int BUS_DW_C     = 32;
    localparam int LANES_C      = BUS_DW_C / USER_DW_C;
    localparam int LANE_W_C     = clog2_f(LANES_C);
    localparam int BEAT_LEN_W_C = 32 - clog2_f(BUS_DW_C / 8);

    // user write request, len is a signed word count
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] len;
    } wreq_t;

    // lane bookkeeping for one accepted bus request
    typedef struct packed {
        logic [LANE_W_C-1:0]     head;
        logic [LANE_W_C-1:0]     tail;
        logic [BEAT_LEN_W_C-1:0] beat_len;
    } offset_t;

    typedef enum logic {
        RSP_SKIP = 1'b0,
        RSP_WAIT = 1'b1
    } rsp_kind_e;

endpackage

// ==== src/sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             ACLK,
    input  logic             ARESET,
    input  logic [WIDTH-1:0] wr_data,
    input  logic             wr_valid,
    output logic             wr_ready,
    output logic [WIDTH-1:0] rd_data,
    output logic             rd_valid,
    input  logic             rd_ready
);
    import axi_store_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? clog2_f(DEPTH) : 1;
    localparam int CNT_W = clog2_f(DEPTH + 1);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    // wraps at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // full refuses a write even when a read happens in the same cycle
    assign wr_ready = (count != CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign push     = wr_valid && wr_ready;
    assign pop      = rd_valid && rd_ready;

    always_ff @(posedge ACLK) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== src/write_request_unit.sv ====
`timescale 1ns/10ps

module write_request_unit #(
    parameter logic [31:0] TARGET_ADDR = 32'h0000_0000,
    parameter int          USER_DW     = 16,
    parameter int          BUS_DW      = 32
) (
    input  logic                     ACLK,
    input  logic                     ARESET,
    input  axi_store_pkg::wreq_t     req,
    input  logic                     req_valid,
    output logic                     req_ready,
    output axi_store_pkg::rsp_kind_e kind,
    output logic                     kind_valid,
    input  logic                     kind_ready,
    output logic [31:0]              bus_awaddr,
    output logic [31:0]              bus_awlen,
    output logic                     bus_aw_valid,
    input  logic                     bus_aw_ready,
    output axi_store_pkg::offset_t   offset,
    output logic                     offset_valid,
    input  logic                     offset_ready
);
    import axi_store_pkg::*;

    localparam int          USER_BYTES = USER_DW / 8;
    localparam int          USER_ALIGN = clog2_f(USER_BYTES);
    localparam int          BUS_ALIGN  = clog2_f(BUS_DW / 8);
    localparam logic [31:0] BASE_ADDR  = TARGET_ADDR & (32'hffff_ffff << USER_ALIGN);

    logic [31:0] addr_q;
    logic [31:0] len_q;
    logic        aw_pending;
    logic        addr_free;
    logic        valid_len;
    logic        req_take;
    logic        aw_take;
    logic [31:0] addr_end;
    logic [31:0] beat_sum;

    // zero and negative counts get a response but no bus traffic
    assign valid_len = (req.len != '0) && !req.len[31];

    // address held back while the offset queue is full
    assign aw_take   = aw_pending && bus_aw_ready && offset_ready;
    assign addr_free = !aw_pending || aw_take;

    assign req_ready  = addr_free && kind_ready;
    assign kind_valid = req_valid && addr_free;
    assign req_take   = req_valid && req_ready;
    assign kind       = valid_len ? RSP_WAIT : RSP_SKIP;

    assign bus_awaddr   = addr_q;
    assign bus_awlen    = len_q;
    assign bus_aw_valid = aw_pending && offset_ready;

    // lane bookkeeping from first and last byte address
    assign addr_end        = addr_q + len_q;
    assign beat_sum        = len_q + 32'(addr_q[BUS_ALIGN-1:0]);
    assign offset.head     = addr_q[BUS_ALIGN-1:USER_ALIGN];
    assign offset.tail     = ~addr_end[BUS_ALIGN-1:USER_ALIGN];
    assign offset.beat_len = beat_sum[31:BUS_ALIGN];
    assign offset_valid    = aw_pending && bus_aw_ready;

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            aw_pending <= 1'b0;
        end else if (req_take) begin
            aw_pending <= valid_len;
        end else if (aw_take) begin
            aw_pending <= 1'b0;
        end
    end

    // word address and count to bytes
    always_ff @(posedge ACLK) begin
        if (req_take) begin
            addr_q <= BASE_ADDR + (req.addr << USER_ALIGN);
            len_q  <= (req.len << USER_ALIGN) - 32'd1;
        end
    end

endmodule

// ==== src/beat_packer.sv ====
`timescale 1ns/10ps

module beat_packer #(
    parameter int USER_DW = 16,
    parameter int BUS_DW  = 32
) (
    input  logic                   ACLK,
    input  logic                   ARESET,
    input  axi_store_pkg::offset_t offset,
    input  logic                   offset_valid,
    output logic                   offset_ready,
    input  logic [USER_DW-1:0]     wdata,
    input  logic [USER_DW/8-1:0]   wstrb,
    input  logic                   w_valid,
    output logic                   w_ready,
    output logic [BUS_DW-1:0]      bus_wdata,
    output logic [BUS_DW/8-1:0]    bus_wstrb,
    output logic                   bus_w_valid,
    input  logic                   bus_w_ready
);
    import axi_store_pkg::*;

    localparam int USER_BYTES = USER_DW / 8;
    localparam int LANES      = BUS_DW / USER_DW;
    localparam int LANE_W     = clog2_f(LANES);
    localparam int BEAT_LEN_W = 32 - clog2_f(BUS_DW / 8);

    offset_t               off_q;
    logic                  off_active;
    logic [BEAT_LEN_W-1:0] beats_left;
    logic [LANES-1:0]      lane_q;
    logic                  first_q;
    logic                  last_q;
    logic [BUS_DW-1:0]     data_q;
    logic [BUS_DW/8-1:0]   strb_q;
    logic                  beat_valid_q;

    logic                  room;
    logic                  w_take;
    logic                  beat_end;
    logic                  off_done;
    logic                  off_load;
    logic [LANE_W-1:0]     tail_lane;
    logic [LANE_W-1:0]     end_lane;
    logic [LANES-1:0]      blank;

    // ==================================================
    // handshakes
    // ==================================================

    // beat buffer is free, or its beat leaves this cycle
    assign room    = !beat_valid_q || bus_w_ready;
    assign w_ready = off_active && room;
    assign w_take  = w_valid && w_ready;

    // last used lane of the current beat
    assign tail_lane = ~off_q.tail;
    assign end_lane  = last_q ? tail_lane : LANE_W'(LANES - 1);
    assign beat_end  = w_take && lane_q[end_lane];
    assign off_done  = beat_end && last_q;

    assign offset_ready = !off_active || off_done;
    assign off_load     = offset_valid && offset_ready;

    // unused lanes before head and after tail
    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            blank[i] = (first_q && (LANE_W'(i) < off_q.head)) ||
                       (last_q && (LANE_W'(i) > tail_lane));
        end
    end

    // ==================================================
    // beat and lane tracking
    // ==================================================

    always_ff @(posedge ACLK) begin
        if (off_load) begin
            off_q <= offset;
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            off_active <= 1'b0;
            first_q    <= 1'b0;
            last_q     <= 1'b0;
            beats_left <= '0;
            lane_q     <= '0;
        end else if (off_load) begin
            off_active <= 1'b1;
            first_q    <= 1'b1;
            last_q     <= (offset.beat_len == '0);
            beats_left <= offset.beat_len;
            lane_q     <= LANES'(1) << offset.head;
        end else if (off_done) begin
            off_active <= 1'b0;
        end else if (beat_end) begin
            first_q    <= 1'b0;
            last_q     <= (beats_left == BEAT_LEN_W'(1));
            beats_left <= beats_left - 1'b1;
            lane_q     <= LANES'(1);
        end else if (w_take) begin
            lane_q <= lane_q << 1;
        end
    end

    // ==================================================
    // lane fill
    // ==================================================

    always_ff @(posedge ACLK) begin
        if (w_take) begin
            for (int i = 0; i < LANES; i++) begin
                if (lane_q[i]) begin
                    data_q[i*USER_DW +: USER_DW]       <= wdata;
                    strb_q[i*USER_BYTES +: USER_BYTES] <= wstrb;
                end else if (blank[i]) begin
                    data_q[i*USER_DW +: USER_DW]       <= '0;
                    strb_q[i*USER_BYTES +: USER_BYTES] <= '0;
                end
            end
        end
    end

    always_ff @(posedge ACLK) begin
        if (ARESET) begin
            beat_valid_q <= 1'b0;
        end else if (beat_end) begin
            beat_valid_q <= 1'b1;
        end else if (bus_w_ready) begin
            beat_valid_q <= 1'b0;
        end
    end

    assign bus_wdata   = data_q;
    assign bus_wstrb   = strb_q;
    assign bus_w_valid = beat_valid_q;

endmodule

// ==== src/response_tracker.sv ====
`timescale 1ns/10ps

module response_tracker #(
    parameter int MAX_OUTSTANDING = 4
) (
    input  logic                     ACLK,
    input  logic                     ARESET,
    input  axi_store_pkg::rsp_kind_e kind,
    input  logic                     kind_valid,
    output logic                     kind_ready,
    input  logic                     bus_b_valid,
    output logic                     bus_b_ready,
    output logic                     ursp_valid,
    input  logic                     ursp_ready
);
    import axi_store_pkg::*;

    logic      head_bits;
    logic      head_valid;
    logic      head_pop;
    rsp_kind_e head_kind;

    // one entry per popped request, in request order
    sync_fifo #(
        .WIDTH (1),
        .DEPTH (MAX_OUTSTANDING)
    ) u_kind_fifo (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .wr_data  (kind),
        .wr_valid (kind_valid),
        .wr_ready (kind_ready),
        .rd_data  (head_bits),
        .rd_valid (head_valid),
        .rd_ready (head_pop)
    );

    assign head_kind = rsp_kind_e'(head_bits);

    // skipped requests retire at once, others wait for the bus
    assign ursp_valid  = head_valid && ((head_kind == RSP_SKIP) || bus_b_valid);
    assign bus_b_ready = head_valid && (head_kind == RSP_WAIT) && ursp_ready;
    assign head_pop    = ursp_valid && ursp_ready;

endmodule

// ==== src/axi_store.sv ====
`timescale 1ns/10ps

module axi_store #(
    parameter logic [31:0] TARGET_ADDR     = 32'h0000_0000,
    parameter int          USER_DW         = axi_store_pkg::USER_DW_C,
    parameter int          BUS_DW          = axi_store_pkg::BUS_DW_C,
    parameter int          MAX_REQS        = 16,
    parameter int          MAX_OUTSTANDING = 4,
    parameter int          BURST_LEN       = 16
) (
    input  logic                 ACLK,
    input  logic                 ARESET,
    // user side
    input  axi_store_pkg::wreq_t user_aw,
    input  logic                 user_aw_valid,
    output logic                 user_aw_ready,
    input  logic [USER_DW-1:0]   user_wdata,
    input  logic [USER_DW/8-1:0] user_wstrb,
    input  logic                 user_w_valid,
    output logic                 user_w_ready,
    output logic                 user_b_valid,
    input  logic                 user_b_ready,
    // bus side
    output logic [31:0]          bus_awaddr,
    output logic [31:0]          bus_awlen,
    output logic                 bus_aw_valid,
    input  logic                 bus_aw_ready,
    output logic [BUS_DW-1:0]    bus_wdata,
    output logic [BUS_DW/8-1:0]  bus_wstrb,
    output logic                 bus_w_valid,
    input  logic                 bus_w_ready,
    input  logic                 bus_b_valid,
    output logic                 bus_b_ready
);
    import axi_store_pkg::*;

    localparam int LANES = BUS_DW / USER_DW;

    typedef struct packed {
        logic [USER_DW/8-1:0] strb;
        logic [USER_DW-1:0]   data;
    } wword_t;

    wreq_t     req;
    logic      req_valid;
    logic      req_ready;
    wword_t    w_in;
    wword_t    w_out;
    logic      w_valid;
    logic      w_ready;
    rsp_kind_e kind;
    logic      kind_valid;
    logic      kind_ready;
    offset_t   off_in;
    logic      off_in_valid;
    logic      off_in_ready;
    offset_t   off_out;
    logic      off_out_valid;
    logic      off_out_ready;
    logic      ursp_valid;
    logic      ursp_ready;

    assign w_in = '{strb: user_wstrb, data: user_wdata};

    // ==================================================
    // queues
    // ==================================================

    sync_fifo #(
        .WIDTH ($bits(wreq_t)),
        .DEPTH (MAX_REQS)
    ) u_req_fifo (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .wr_data  (user_aw),
        .wr_valid (user_aw_valid),
        .wr_ready (user_aw_ready),
        .rd_data  (req),
        .rd_valid (req_valid),
        .rd_ready (req_ready)
    );

    // room for a full burst of user words
    sync_fifo #(
        .WIDTH ($bits(wword_t)),
        .DEPTH (BURST_LEN * LANES)
    ) u_data_fifo (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .wr_data  (w_in),
        .wr_valid (user_w_valid),
        .wr_ready (user_w_ready),
        .rd_data  (w_out),
        .rd_valid (w_valid),
        .rd_ready (w_ready)
    );

    sync_fifo #(
        .WIDTH ($bits(offset_t)),
        .DEPTH (MAX_OUTSTANDING)
    ) u_off_fifo (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .wr_data  (off_in),
        .wr_valid (off_in_valid),
        .wr_ready (off_in_ready),
        .rd_data  (off_out),
        .rd_valid (off_out_valid),
        .rd_ready (off_out_ready)
    );

    // responses carry no payload
    sync_fifo #(
        .WIDTH (1),
        .DEPTH (MAX_REQS)
    ) u_rsp_fifo (
        .ACLK     (ACLK),
        .ARESET   (ARESET),
        .wr_data  (1'b1),
        .wr_valid (ursp_valid),
        .wr_ready (ursp_ready),
        .rd_data  (),
        .rd_valid (user_b_valid),
        .rd_ready (user_b_ready)
    );

    // ==================================================
    // engines
    // ==================================================

    write_request_unit #(
        .TARGET_ADDR (TARGET_ADDR),
        .USER_DW     (USER_DW),
        .BUS_DW      (BUS_DW)
    ) u_wr_req (
        .ACLK         (ACLK),
        .ARESET       (ARESET),
        .req          (req),
        .req_valid    (req_valid),
        .req_ready    (req_ready),
        .kind         (kind),
        .kind_valid   (kind_valid),
        .kind_ready   (kind_ready),
        .bus_awaddr   (bus_awaddr),
        .bus_awlen    (bus_awlen),
        .bus_aw_valid (bus_aw_valid),
        .bus_aw_ready (bus_aw_ready),
        .offset       (off_in),
        .offset_valid (off_in_valid),
        .offset_ready (off_in_ready)
    );

    beat_packer #(
        .USER_DW (USER_DW),
        .BUS_DW  (BUS_DW)
    ) u_packer (
        .ACLK         (ACLK),
        .ARESET       (ARESET),
        .offset       (off_out),
        .offset_valid (off_out_valid),
        .offset_ready (off_out_ready),
        .wdata        (w_out.data),
        .wstrb        (w_out.strb),
        .w_valid      (w_valid),
        .w_ready      (w_ready),
        .bus_wdata    (bus_wdata),
        .bus_wstrb    (bus_wstrb),
        .bus_w_valid  (bus_w_valid),
        .bus_w_ready  (bus_w_ready)
    );

    response_tracker #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING)
    ) u_rsp (
        .ACLK        (ACLK),
        .ARESET      (ARESET),
        .kind        (kind),
        .kind_valid  (kind_valid),
        .kind_ready  (kind_ready),
        .bus_b_valid (bus_b_valid),
        .bus_b_ready (bus_b_ready),
        .ursp_valid  (ursp_valid),
        .ursp_ready  (ursp_ready)
    );

endmodule

// ==== sim/tb_axi_store.sv ====
`timescale 1ns/10ps

module tb_axi_store;
    import axi_store_pkg::*;

    localparam logic [31:0] TARGET_ADDR = 32'h0000_1000;
    localparam int          USER_DW     = 16;
    localparam int          BUS_DW      = 32;
    localparam int          LANES       = BUS_DW / USER_DW;
    localparam int          NUM_REQS    = 48;
    localparam int          TIMEOUT_CYC = 20000;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] len;
    } aw_t;

    typedef struct packed {
        logic [BUS_DW/8-1:0] strb;
        logic [BUS_DW-1:0]   data;
    } beat_t;

    typedef struct packed {
        logic [USER_DW/8-1:0] strb;
        logic [USER_DW-1:0]   data;
    } word_t;

    logic                 ACLK          = 1'b0;
    logic                 ARESET        = 1'b1;
    wreq_t                user_aw       = '0;
    logic                 user_aw_valid = 1'b0;
    logic                 user_aw_ready;
    logic [USER_DW-1:0]   user_wdata    = '0;
    logic [USER_DW/8-1:0] user_wstrb    = '0;
    logic                 user_w_valid  = 1'b0;
    logic                 user_w_ready;
    logic                 user_b_valid;
    logic                 user_b_ready  = 1'b0;
    logic [31:0]          bus_awaddr;
    logic [31:0]          bus_awlen;
    logic                 bus_aw_valid;
    logic                 bus_aw_ready  = 1'b0;
    logic [BUS_DW-1:0]    bus_wdata;
    logic [BUS_DW/8-1:0]  bus_wstrb;
    logic                 bus_w_valid;
    logic                 bus_w_ready   = 1'b0;
    logic                 bus_b_valid   = 1'b0;
    logic                 bus_b_ready;

    // stimulus lists and expected traffic, all in request order
    wreq_t       reqs[$];
    word_t       words[$];
    aw_t         exp_aw[$];
    beat_t       exp_beat[$];
    int          exp_nbeats[$];
    rsp_kind_e   exp_kind[$];

    logic [31:0] lfsr      = 32'hd6c0_8930;
    int          req_next  = 0;
    int          w_next    = 0;
    int          beat_cnt  = 0;
    int          b_credit  = 0;
    int          b_done    = 0;
    int          b_used    = 0;
    int          rsp_count = 0;
    logic        aw_stall  = 1'b0;
    logic        w_stall   = 1'b0;
    logic        ub_stall  = 1'b0;
    aw_t         aw_hold;
    beat_t       w_hold;
    aw_t         cur_aw;
    beat_t       cur_beat;
    rsp_kind_e   kind_now;

    axi_store #(
        .TARGET_ADDR     (TARGET_ADDR),
        .USER_DW         (USER_DW),
        .BUS_DW          (BUS_DW),
        .MAX_REQS        (16),
        .MAX_OUTSTANDING (4),
        .BURST_LEN       (16)
    ) uut (
        .ACLK          (ACLK),
        .ARESET        (ARESET),
        .user_aw       (user_aw),
        .user_aw_valid (user_aw_valid),
        .user_aw_ready (user_aw_ready),
        .user_wdata    (user_wdata),
        .user_wstrb    (user_wstrb),
        .user_w_valid  (user_w_valid),
        .user_w_ready  (user_w_ready),
        .user_b_valid  (user_b_valid),
        .user_b_ready  (user_b_ready),
        .bus_awaddr    (bus_awaddr),
        .bus_awlen     (bus_awlen),
        .bus_aw_valid  (bus_aw_valid),
        .bus_aw_ready  (bus_aw_ready),
        .bus_wdata     (bus_wdata),
        .bus_wstrb     (bus_wstrb),
        .bus_w_valid   (bus_w_valid),
        .bus_w_ready   (bus_w_ready),
        .bus_b_valid   (bus_b_valid),
        .bus_b_ready   (bus_b_ready)
    );

    always #2 ACLK = ~ACLK;

    // ==================================================
    // random source and reference model
    // ==================================================

    // taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], next_bit()};
        end
        return r;
    endfunction

    // word k of a request lands in lane (a+k) mod LANES of beat (a+k)/LANES
    function automatic void build_expect(input wreq_t r, input int first);
        int    n;
        int    a;
        int    b0;
        int    nb;
        int    k;
        aw_t   aw;
        beat_t bt;
        n = $signed(r.len);
        a = r.addr;
        if (n <= 0) begin
            exp_kind.push_back(RSP_SKIP);
            return;
        end
        exp_kind.push_back(RSP_WAIT);
        aw.addr = TARGET_ADDR + 2 * r.addr;
        aw.len  = 2 * n - 1;
        exp_aw.push_back(aw);
        b0 = a / LANES;
        nb = (a + n - 1) / LANES - b0 + 1;
        for (int bi = 0; bi < nb; bi++) begin
            bt = '0;
            for (int ln = 0; ln < LANES; ln++) begin
                k = (b0 + bi) * LANES + ln - a;
                if (k >= 0 && k < n) begin
                    bt.data[ln*USER_DW +: USER_DW]         = words[first + k].data;
                    bt.strb[ln*(USER_DW/8) +: USER_DW/8] = words[first + k].strb;
                end
            end
            exp_beat.push_back(bt);
        end
        exp_nbeats.push_back(nb);
    endfunction

    // ==================================================
    // checks
    // ==================================================

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_aw(input aw_t exp_v, input aw_t got_v);
        if (got_v.addr !== exp_v.addr) begin
            report_failure($sformatf("mismatch at %0t: bus_awaddr expected %h, got %h",
                                     $time, exp_v.addr, got_v.addr));
        end
        if (got_v.len !== exp_v.len) begin
            report_failure($sformatf("mismatch at %0t: bus_awlen expected %h, got %h",
                                     $time, exp_v.len, got_v.len));
        end
    endtask

    task automatic check_beat(input beat_t exp_v, input beat_t got_v);
        if (got_v.data !== exp_v.data) begin
            report_failure($sformatf("mismatch at %0t: bus_wdata expected %h, got %h",
                                     $time, exp_v.data, got_v.data));
        end
        if (got_v.strb !== exp_v.strb) begin
            report_failure($sformatf("mismatch at %0t: bus_wstrb expected %h, got %h",
                                     $time, exp_v.strb, got_v.strb));
        end
    endtask

    // b_ahead counts bus responses not yet matched by a user response
    task automatic check_rsp(input rsp_kind_e kind, input int b_ahead);
        if (kind == RSP_WAIT && b_ahead <= 0) begin
            report_failure("user response for a bus write came before its bus response");
        end
    endtask

    // ==================================================
    // monitor and drivers, one process for a fixed draw order
    // ==================================================

    always @(posedge ACLK) begin
        if (!ARESET) begin
            cur_aw.addr   = bus_awaddr;
            cur_aw.len    = bus_awlen;
            cur_beat.data = bus_wdata;
            cur_beat.strb = bus_wstrb;

            // user side first, so a bus response on this edge does not count yet
            if (ub_stall && !user_b_valid) begin
                report_failure("user_b_valid dropped before its transfer");
            end
            if (user_b_valid && user_b_ready) begin
                if (exp_kind.size() == 0) begin
                    report_failure("user response with no request outstanding");
                end
                kind_now = exp_kind.pop_front();
                check_rsp(kind_now, b_done - b_used);
                if (kind_now == RSP_WAIT) begin
                    b_used++;
                end
                rsp_count++;
            end
            ub_stall = user_b_valid && !user_b_ready;

            if (bus_b_valid && bus_b_ready) begin
                b_done++;
            end

            if (aw_stall) begin
                if (!bus_aw_valid) begin
                    report_failure("bus_aw_valid dropped before its transfer");
                end
                check_aw(aw_hold, cur_aw);
            end
            if (bus_aw_valid && bus_aw_ready) begin
                if (exp_aw.size() == 0) begin
                    report_failure("bus address issued with no valid request outstanding");
                end
                check_aw(exp_aw.pop_front(), cur_aw);
            end
            aw_stall = bus_aw_valid && !bus_aw_ready;
            aw_hold  = cur_aw;

            if (w_stall) begin
                if (!bus_w_valid) begin
                    report_failure("bus_w_valid dropped before its transfer");
                end
                check_beat(w_hold, cur_beat);
            end
            if (bus_w_valid && bus_w_ready) begin
                if (exp_beat.size() == 0) begin
                    report_failure("bus beat issued with no beat outstanding");
                end
                check_beat(exp_beat.pop_front(), cur_beat);
                beat_cnt++;
                // whole burst seen, the slave may answer it
                if (beat_cnt == exp_nbeats[0]) begin
                    void'(exp_nbeats.pop_front());
                    beat_cnt = 0;
                    b_credit++;
                end
            end
            w_stall = bus_w_valid && !bus_w_ready;
            w_hold  = cur_beat;

            if (!user_aw_valid || user_aw_ready) begin
                if (req_next < reqs.size() && next_bit()) begin
                    user_aw       <= reqs[req_next];
                    user_aw_valid <= 1'b1;
                    req_next++;
                end else begin
                    user_aw_valid <= 1'b0;
                end
            end
            if (!user_w_valid || user_w_ready) begin
                if (w_next < words.size() && next_bit()) begin
                    user_wdata   <= words[w_next].data;
                    user_wstrb   <= words[w_next].strb;
                    user_w_valid <= 1'b1;
                    w_next++;
                end else begin
                    user_w_valid <= 1'b0;
                end
            end
            if (!bus_b_valid || bus_b_ready) begin
                if (b_credit > 0 && next_bit()) begin
                    bus_b_valid <= 1'b1;
                    b_credit--;
                end else begin
                    bus_b_valid <= 1'b0;
                end
            end
            bus_aw_ready <= (rand_bits(2) != '0);
            bus_w_ready  <= (rand_bits(2) != '0);
            user_b_ready <= (rand_bits(2) != '0);
        end
    end

    // ==================================================
    // sequence
    // ==================================================

    initial begin
        wreq_t r;
        word_t wd;
        int    v;
        int    len_i;
        int    first;
        int    cyc;
        // counts 0, -1 and -2 are rejected, others run 1 to 13 words
        for (int i = 0; i < NUM_REQS; i++) begin
            r.addr = rand_bits(10);
            v      = rand_bits(4);
            len_i  = (v < 3) ? -v : v - 2;
            r.len  = len_i;
            first  = words.size();
            for (int k = 0; k < len_i; k++) begin
                wd.data = 16'(rand_bits(16));
                wd.strb = 2'(rand_bits(2));
                words.push_back(wd);
            end
            reqs.push_back(r);
            build_expect(r, first);
        end

        for (int i = 0; i < 4; i++) begin
            @(posedge ACLK);
        end
        if (bus_aw_valid || bus_w_valid || bus_b_ready || user_b_valid) begin
            report_failure("a valid or bus_b_ready output is high during reset");
        end
        if (!user_aw_ready || !user_w_ready) begin
            report_failure("user ready outputs are low with empty queues");
        end
        ARESET <= 1'b0;

        for (cyc = 0; cyc < TIMEOUT_CYC && rsp_count < NUM_REQS; cyc++) begin
            @(posedge ACLK);
        end
        if (rsp_count < NUM_REQS) begin
            report_failure("timed out waiting for all user responses");
        end
        // idle time to catch late extra traffic
        repeat (20) @(posedge ACLK);

        if (exp_aw.size() == 0 && exp_beat.size() == 0 && exp_kind.size() == 0 &&
            rsp_count == NUM_REQS && b_credit == 0 && w_next == words.size()) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            report_failure("run ended with addresses, beats or responses left over");
        end
    end

endmodule

// ==== sim.f ====
src/axi_store_pkg.sv
src/sync_fifo.sv
src/write_request_unit.sv
src/beat_packer.sv
src/response_tracker.sv
src/axi_store.sv
sim/tb_axi_store.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/10ps
TOP       ?= tb_axi_store
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
